/* logic/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int regCount = 32;
    localparam int linkReg = 31;

    typedef logic [dataWidth-1:0] word_t;
    typedef logic [regAddrWidth-1:0] regAddr_t;
    // Word address, byte offset dropped
    typedef logic [dataWidth-3:0] memAddr_t;

    // Primary opcodes
    localparam logic [5:0] opcodeRType = 6'h00;
    localparam logic [5:0] opcodeJ = 6'h02;
    localparam logic [5:0] opcodeJal = 6'h03;
    localparam logic [5:0] opcodeBeq = 6'h04;
    localparam logic [5:0] opcodeBne = 6'h05;
    localparam logic [5:0] opcodeAddiu = 6'h09;
    localparam logic [5:0] opcodeOri = 6'h0d;
    localparam logic [5:0] opcodeLw = 6'h23;
    localparam logic [5:0] opcodeSw = 6'h2b;

    // R-type function codes
    localparam logic [5:0] functSll = 6'h00;
    localparam logic [5:0] functJr = 6'h08;
    localparam logic [5:0] functAddu = 6'h21;
    localparam logic [5:0] functSubu = 6'h23;
    localparam logic [5:0] functAnd = 6'h24;
    localparam logic [5:0] functOr = 6'h25;
    localparam logic [5:0] functSlt = 6'h2a;

    // aluAdd is zero so a cleared control word still adds
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr = 3'd3,
        aluSlt = 3'd4,
        aluSll = 3'd5
    } aluOp_t;

    typedef enum logic [1:0] {
        fwdReg = 2'd0,
        fwdMem = 2'd1,
        fwdWb = 2'd2
    } fwdSel_t;

    typedef struct packed {
        logic regWrite;
        logic memToReg;
        logic memRead;
        logic memWrite;
        logic aluSrcPc;
        logic aluSrcImm;
        logic beq;
        logic bne;
        logic jumpImm;
        logic jumpReg;
        logic link;
        aluOp_t aluOp;
    } ctrl_t;

    typedef struct packed {
        word_t instr;
        word_t pcPlus4;
    } ifId_t;

    typedef struct packed {
        ctrl_t ctrl;
        word_t pcPlus4;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t rd;
        word_t rsData;
        word_t rtData;
        word_t imm;
    } idEx_t;

    typedef struct packed {
        logic regWrite;
        logic memToReg;
        logic memRead;
        logic memWrite;
        word_t aluRes;
        regAddr_t rd;
        word_t storeData;
    } exMem_t;

    typedef struct packed {
        logic regWrite;
        logic memToReg;
        regAddr_t rd;
        word_t loadData;
        word_t aluRes;
    } memWb_t;

    typedef struct packed {
        logic read;
        logic write;
        memAddr_t addr;
        word_t wdata;
    } dmemReq_t;

endpackage

`default_nettype wire

/* logic/decodeUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeUnit (
    input  var cpuPkg::word_t    instr_i,
    output cpuPkg::ctrl_t        ctrl_o,
    output cpuPkg::regAddr_t     rs_o,
    output cpuPkg::regAddr_t     rt_o,
    output cpuPkg::regAddr_t     rd_o,
    output cpuPkg::word_t        imm_o
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr_i[31:26];
    assign funct = instr_i[5:0];
    assign rs_o = instr_i[25:21];
    assign rt_o = instr_i[20:16];

    always_comb begin
        ctrl_o = '0;
        case (opcode)
            cpuPkg::opcodeRType: begin
                ctrl_o.regWrite = 1'b1;
                case (funct)
                    cpuPkg::functAddu: ctrl_o.aluOp = cpuPkg::aluAdd;
                    cpuPkg::functSubu: ctrl_o.aluOp = cpuPkg::aluSub;
                    cpuPkg::functAnd: ctrl_o.aluOp = cpuPkg::aluAnd;
                    cpuPkg::functOr: ctrl_o.aluOp = cpuPkg::aluOr;
                    cpuPkg::functSlt: ctrl_o.aluOp = cpuPkg::aluSlt;
                    cpuPkg::functSll: ctrl_o.aluOp = cpuPkg::aluSll;
                    cpuPkg::functJr: begin
                        ctrl_o.regWrite = 1'b0;
                        ctrl_o.jumpReg = 1'b1;
                    end
                    // Unsupported function code becomes a nop
                    default: ctrl_o = '0;
                endcase
            end
            cpuPkg::opcodeAddiu: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
            end
            cpuPkg::opcodeOri: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.aluOp = cpuPkg::aluOr;
            end
            cpuPkg::opcodeLw: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.memToReg = 1'b1;
                ctrl_o.memRead = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
            end
            cpuPkg::opcodeSw: begin
                ctrl_o.memWrite = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
            end
            // Branch target is PC+4 plus the scaled offset
            cpuPkg::opcodeBeq: begin
                ctrl_o.beq = 1'b1;
                ctrl_o.aluSrcPc = 1'b1;
            end
            cpuPkg::opcodeBne: begin
                ctrl_o.bne = 1'b1;
                ctrl_o.aluSrcPc = 1'b1;
            end
            cpuPkg::opcodeJ: ctrl_o.jumpImm = 1'b1;
            cpuPkg::opcodeJal: begin
                ctrl_o.jumpImm = 1'b1;
                ctrl_o.link = 1'b1;
                ctrl_o.regWrite = 1'b1;
                ctrl_o.aluSrcPc = 1'b1;
            end
            default: ctrl_o = '0;
        endcase
    end

    always_comb begin
        if (opcode == cpuPkg::opcodeJal) begin
            rd_o = cpuPkg::regAddr_t'(cpuPkg::linkReg);
        end else if (opcode == cpuPkg::opcodeRType) begin
            rd_o = instr_i[15:11];
        end else begin
            rd_o = instr_i[20:16];
        end
    end

    always_comb begin
        if (opcode == cpuPkg::opcodeJ || opcode == cpuPkg::opcodeJal) begin
            imm_o = {4'b0000, instr_i[25:0], 2'b00};
        end else if (opcode == cpuPkg::opcodeOri) begin
            // Logical immediates are zero-extended
            imm_o = {16'h0000, instr_i[15:0]};
        end else begin
            imm_o = {{16{instr_i[15]}}, instr_i[15:0]};
        end
    end

endmodule

`default_nettype wire

/* logic/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  var logic             clk,
    input  var logic             rst,
    input  var logic             writeEn_i,
    input  var cpuPkg::regAddr_t writeAddr_i,
    input  var cpuPkg::word_t    writeData_i,
    input  var cpuPkg::regAddr_t readAddrA_i,
    input  var cpuPkg::regAddr_t readAddrB_i,
    output cpuPkg::word_t        readDataA_o,
    output cpuPkg::word_t        readDataB_o
);

    cpuPkg::word_t regs [cpuPkg::regCount];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < cpuPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn_i && writeAddr_i != '0) begin
            regs[writeAddr_i] <= writeData_i;
        end
    end

    // Writeback data bypasses the array so decode sees it this cycle
    function automatic cpuPkg::word_t readPort(input cpuPkg::regAddr_t addr);
        if (writeEn_i && writeAddr_i != '0 && writeAddr_i == addr) begin
            return writeData_i;
        end
        return regs[addr];
    endfunction

    always_comb begin
        readDataA_o = readPort(readAddrA_i);
        readDataB_o = readPort(readAddrB_i);
    end

    zeroRegRead: assert property (@(posedge clk) disable iff (rst)
        (readAddrA_i == '0 |-> readDataA_o == '0) and
        (readAddrB_i == '0 |-> readDataB_o == '0));

endmodule

`default_nettype wire

/* logic/aluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  var cpuPkg::aluOp_t op_i,
    input  var cpuPkg::word_t  operandA_i,
    input  var cpuPkg::word_t  operandB_i,
    input  var logic [4:0]     shamt_i,
    output cpuPkg::word_t      result_o
);

    logic lessThan;

    // Signed compare for slt
    assign lessThan = $signed(operandA_i) < $signed(operandB_i);

    always_comb begin
        case (op_i)
            cpuPkg::aluAdd: result_o = operandA_i + operandB_i;
            cpuPkg::aluSub: result_o = operandA_i - operandB_i;
            cpuPkg::aluAnd: result_o = operandA_i & operandB_i;
            cpuPkg::aluOr: result_o = operandA_i | operandB_i;
            cpuPkg::aluSlt: result_o = {{(cpuPkg::dataWidth-1){1'b0}}, lessThan};
            // sll shifts rt, not rs
            cpuPkg::aluSll: result_o = operandB_i << shamt_i;
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/hazardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  var cpuPkg::regAddr_t idRs_i,
    input  var cpuPkg::regAddr_t idRt_i,
    input  var cpuPkg::regAddr_t exRs_i,
    input  var cpuPkg::regAddr_t exRt_i,
    input  var cpuPkg::regAddr_t exRd_i,
    input  var logic             exMemRead_i,
    input  var cpuPkg::regAddr_t memRd_i,
    input  var logic             memRegWrite_i,
    input  var cpuPkg::regAddr_t wbRd_i,
    input  var logic             wbRegWrite_i,
    input  var logic             redirect_i,
    output cpuPkg::fwdSel_t      fwdA_o,
    output cpuPkg::fwdSel_t      fwdB_o,
    output logic                 pcWrite_o,
    output logic                 ifIdWrite_o,
    output logic                 ifIdFlush_o,
    output logic                 idExFlush_o
);

    logic loadUse;

    // Youngest producer wins
    function automatic cpuPkg::fwdSel_t pickSource(input cpuPkg::regAddr_t src);
        if (memRegWrite_i && memRd_i != '0 && memRd_i == src) begin
            return cpuPkg::fwdMem;
        end else if (wbRegWrite_i && wbRd_i != '0 && wbRd_i == src) begin
            return cpuPkg::fwdWb;
        end
        return cpuPkg::fwdReg;
    endfunction

    always_comb begin
        fwdA_o = pickSource(exRs_i);
        fwdB_o = pickSource(exRt_i);
    end

    // Load result is not ready until writeback, so hold decode one cycle
    assign loadUse = exMemRead_i && exRd_i != '0 &&
                     (exRd_i == idRs_i || exRd_i == idRt_i);

    // Redirect overrides the stall, younger instructions are dead anyway
    assign pcWrite_o = !loadUse || redirect_i;
    assign ifIdWrite_o = !loadUse;
    assign ifIdFlush_o = redirect_i;
    assign idExFlush_o = loadUse || redirect_i;

endmodule

`default_nettype wire

/* logic/stageReg.sv */
`timescale 1ns/1ps
`default_nettype none

module stageReg #(
    parameter type payload_t = logic
) (
    input  var logic     clk,
    input  var logic     rst,
    input  var logic     write_i,
    input  var logic     flush_i,
    input  var payload_t d_i,
    output payload_t     q_o
);

    // All-zero payload is a bubble
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            q_o <= '0;
        end else if (write_i) begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

/* logic/mipsPipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsPipeline (
    input  var logic             clk,
    input  var logic             rst,
    output cpuPkg::memAddr_t     imemAddr_o,
    input  var cpuPkg::word_t    imemData_i,
    output cpuPkg::dmemReq_t     dmemReq_o,
    input  var cpuPkg::word_t    dmemRdata_i
);

    cpuPkg::word_t pc;
    cpuPkg::word_t pcPlus4;
    cpuPkg::word_t nextPc;

    cpuPkg::ifId_t ifIdD, ifIdQ;
    cpuPkg::idEx_t idExD, idExQ;
    cpuPkg::exMem_t exMemD, exMemQ;
    cpuPkg::memWb_t memWbD, memWbQ;

    logic pcWrite, ifIdWrite, ifIdFlush, idExFlush;
    cpuPkg::fwdSel_t fwdA, fwdB;

    cpuPkg::word_t rsFwd, rtFwd;
    cpuPkg::word_t aluA, aluB, aluRes;
    cpuPkg::word_t wbData;
    logic rsEqRt, branchTaken, redirect;

    // Fetch
    assign pcPlus4 = pc + 32'd4;
    assign imemAddr_o = pc[31:2];

    // Jumps first, then branch, else sequential
    always_comb begin
        if (idExQ.ctrl.jumpImm) begin
            nextPc = idExQ.imm;
        end else if (idExQ.ctrl.jumpReg) begin
            nextPc = rsFwd;
        end else if (branchTaken) begin
            nextPc = aluRes;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (pcWrite) begin
            pc <= nextPc;
        end
    end

    assign ifIdD.instr = imemData_i;
    assign ifIdD.pcPlus4 = pcPlus4;

    stageReg #(.payload_t(cpuPkg::ifId_t)) ifIdReg (
        .clk(clk), .rst(rst), .write_i(ifIdWrite), .flush_i(ifIdFlush),
        .d_i(ifIdD), .q_o(ifIdQ)
    );

    // Decode
    decodeUnit decoder (
        .instr_i(ifIdQ.instr), .ctrl_o(idExD.ctrl), .rs_o(idExD.rs),
        .rt_o(idExD.rt), .rd_o(idExD.rd), .imm_o(idExD.imm)
    );

    registerFile regFile (
        .clk(clk), .rst(rst),
        .writeEn_i(memWbQ.regWrite), .writeAddr_i(memWbQ.rd), .writeData_i(wbData),
        .readAddrA_i(idExD.rs), .readAddrB_i(idExD.rt),
        .readDataA_o(idExD.rsData), .readDataB_o(idExD.rtData)
    );

    assign idExD.pcPlus4 = ifIdQ.pcPlus4;

    stageReg #(.payload_t(cpuPkg::idEx_t)) idExReg (
        .clk(clk), .rst(rst), .write_i(1'b1), .flush_i(idExFlush),
        .d_i(idExD), .q_o(idExQ)
    );

    // Execute
    hazardUnit hazards (
        .idRs_i(idExD.rs), .idRt_i(idExD.rt),
        .exRs_i(idExQ.rs), .exRt_i(idExQ.rt), .exRd_i(idExQ.rd),
        .exMemRead_i(idExQ.ctrl.memRead),
        .memRd_i(exMemQ.rd), .memRegWrite_i(exMemQ.regWrite),
        .wbRd_i(memWbQ.rd), .wbRegWrite_i(memWbQ.regWrite),
        .redirect_i(redirect),
        .fwdA_o(fwdA), .fwdB_o(fwdB),
        .pcWrite_o(pcWrite), .ifIdWrite_o(ifIdWrite),
        .ifIdFlush_o(ifIdFlush), .idExFlush_o(idExFlush)
    );

    assign rsFwd = fwdA == cpuPkg::fwdMem ? exMemQ.aluRes :
                   fwdA == cpuPkg::fwdWb  ? wbData : idExQ.rsData;
    assign rtFwd = fwdB == cpuPkg::fwdMem ? exMemQ.aluRes :
                   fwdB == cpuPkg::fwdWb  ? wbData : idExQ.rtData;

    assign aluA = idExQ.ctrl.aluSrcPc ? idExQ.pcPlus4 : rsFwd;
    // Link adds zero so the ALU passes PC+4 through
    assign aluB = (idExQ.ctrl.beq || idExQ.ctrl.bne) ? {idExQ.imm[29:0], 2'b00} :
                  idExQ.ctrl.link      ? '0 :
                  idExQ.ctrl.aluSrcImm ? idExQ.imm : rtFwd;

    aluUnit alu (
        .op_i(idExQ.ctrl.aluOp), .operandA_i(aluA), .operandB_i(aluB),
        .shamt_i(idExQ.imm[10:6]), .result_o(aluRes)
    );

    assign rsEqRt = rsFwd == rtFwd;
    assign branchTaken = (idExQ.ctrl.beq && rsEqRt) || (idExQ.ctrl.bne && !rsEqRt);
    assign redirect = branchTaken || idExQ.ctrl.jumpImm || idExQ.ctrl.jumpReg;

    assign exMemD.regWrite = idExQ.ctrl.regWrite;
    assign exMemD.memToReg = idExQ.ctrl.memToReg;
    assign exMemD.memRead = idExQ.ctrl.memRead;
    assign exMemD.memWrite = idExQ.ctrl.memWrite;
    assign exMemD.aluRes = aluRes;
    assign exMemD.rd = idExQ.rd;
    assign exMemD.storeData = rtFwd;

    stageReg #(.payload_t(cpuPkg::exMem_t)) exMemReg (
        .clk(clk), .rst(rst), .write_i(1'b1), .flush_i(1'b0),
        .d_i(exMemD), .q_o(exMemQ)
    );

    // Memory
    assign dmemReq_o.read = exMemQ.memRead;
    assign dmemReq_o.write = exMemQ.memWrite;
    assign dmemReq_o.addr = exMemQ.aluRes[31:2];
    assign dmemReq_o.wdata = exMemQ.storeData;

    assign memWbD.regWrite = exMemQ.regWrite;
    assign memWbD.memToReg = exMemQ.memToReg;
    assign memWbD.rd = exMemQ.rd;
    assign memWbD.loadData = dmemRdata_i;
    assign memWbD.aluRes = exMemQ.aluRes;

    stageReg #(.payload_t(cpuPkg::memWb_t)) memWbReg (
        .clk(clk), .rst(rst), .write_i(1'b1), .flush_i(1'b0),
        .d_i(memWbD), .q_o(memWbQ)
    );

    // Writeback
    assign wbData = memWbQ.memToReg ? memWbQ.loadData : memWbQ.aluRes;

    // Load data only exists in writeback, the load-use stall must cover this
    noLoadFromMem: assert property (@(posedge clk) disable iff (rst)
        (fwdA == cpuPkg::fwdMem || fwdB == cpuPkg::fwdMem) |-> !exMemQ.memRead);

endmodule

`default_nettype wire

/* test/tbClock.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    input  var logic resetReq_i,
    output logic     clk_o,
    output logic     rst_o
);

    localparam int halfPeriod = 5;
    localparam int resetCycles = 16;

    logic clkReg = 1'b0;
    logic rstReg = 1'b1;
    int unsigned resetCount = 1;

    // 10 ns period
    always #halfPeriod clkReg = ~clkReg;

    // Reset covers resetCycles rising edges, at power-up or on request
    always @(negedge clkReg) begin
        if (resetReq_i) begin
            rstReg <= 1'b1;
            resetCount <= 1;
        end else if (rstReg) begin
            if (resetCount == resetCycles) begin
                rstReg <= 1'b0;
            end
            resetCount <= resetCount + 1;
        end
    end

    assign clk_o = clkReg;
    assign rst_o = rstReg;

endmodule

`default_nettype wire

/* test/tbMips.sv */
`timescale 1ns/1ps
`default_nettype none

module tbMips;

    localparam int doneTimeout = 400;
    localparam int resetTimeout = 40;
    localparam cpuPkg::memAddr_t doneAddr = 30'h0ff;
    localparam logic [15:0] doneMarker = 16'hd0e5;

    logic clk;
    logic rst;
    logic resetReq = 1'b0;
    cpuPkg::memAddr_t imemAddr;
    cpuPkg::word_t imemData;
    cpuPkg::dmemReq_t dmemReq;
    cpuPkg::word_t dmemRdata;

    cpuPkg::word_t imem [256] = '{default: '0};
    cpuPkg::word_t dmem [256] = '{default: '0};
    cpuPkg::dmemReq_t expStores [$];
    cpuPkg::dmemReq_t gotStores [$];
    int unsigned loadPtr = 0;
    logic [31:0] rngState = 32'ha1a30893;
    int mismatches = 0;
    int failures = 0;
    cpuPkg::memAddr_t pcAtRelease;
    cpuPkg::dmemReq_t reqAtRelease;

    tbClock clkGen (.resetReq_i(resetReq), .clk_o(clk), .rst_o(rst));

    mipsPipeline dut_i (
        .clk(clk), .rst(rst),
        .imemAddr_o(imemAddr), .imemData_i(imemData),
        .dmemReq_o(dmemReq), .dmemRdata_i(dmemRdata)
    );

    // Both memories answer in the same cycle
    assign imemData = imem[imemAddr[7:0]];
    assign dmemRdata = dmem[dmemReq.addr[7:0]];

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 256; i++) begin
                dmem[8'(i)] <= 32'h5a5a_0000 | 32'(i);
            end
        end else if (dmemReq.write) begin
            dmem[dmemReq.addr[7:0]] <= dmemReq.wdata;
        end
    end

    function automatic cpuPkg::word_t nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic cpuPkg::word_t signExt(input logic [15:0] value);
        return {{16{value[15]}}, value};
    endfunction

    task automatic checkWord(input string name, input cpuPkg::word_t expected,
            input cpuPkg::word_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic checkReq(input string name, input cpuPkg::dmemReq_t expected,
            input cpuPkg::dmemReq_t actual);
        string expText;
        string actText;
        if (actual !== expected) begin
            expText = $sformatf("rd=%b wr=%b addr=%h data=%h", expected.read,
                expected.write, expected.addr, expected.wdata);
            actText = $sformatf("rd=%b wr=%b addr=%h data=%h", actual.read,
                actual.write, actual.addr, actual.wdata);
            $display("MISMATCH %s: expected %s, actual %s", name, expText, actText);
            mismatches++;
        end
    endtask

    task automatic place(input cpuPkg::word_t instr);
        imem[8'(loadPtr)] = instr;
        loadPtr++;
    endtask

    task automatic emitR(input logic [5:0] funct, input cpuPkg::regAddr_t rd,
            input cpuPkg::regAddr_t rs, input cpuPkg::regAddr_t rt, input logic [4:0] shamt);
        place({cpuPkg::opcodeRType, rs, rt, rd, shamt, funct});
    endtask

    task automatic emitI(input logic [5:0] op, input cpuPkg::regAddr_t rt,
            input cpuPkg::regAddr_t rs, input logic [15:0] imm);
        place({op, rs, rt, imm});
    endtask

    task automatic emitJ(input logic [5:0] op, input cpuPkg::word_t target);
        place({op, target[27:2]});
    endtask

    task automatic emitStore(input cpuPkg::regAddr_t rt, input logic [15:0] offset);
        emitI(cpuPkg::opcodeSw, rt, 5'd0, offset);
    endtask

    task automatic expectStore(input logic [15:0] offset, input cpuPkg::word_t data);
        cpuPkg::dmemReq_t req;
        req.read = 1'b0;
        req.write = 1'b1;
        req.addr = {16'd0, offset[15:2]};
        req.wdata = data;
        expStores.push_back(req);
    endtask

    task automatic expectLoad(input logic [15:0] offset);
        cpuPkg::dmemReq_t req;
        req.read = 1'b1;
        req.write = 1'b0;
        req.addr = {16'd0, offset[15:2]};
        // Write data means nothing on a load
        req.wdata = '0;
        expStores.push_back(req);
    endtask

    task automatic newProgram();
        // Filler is an ori into r0, harmless when fetched
        for (int i = 0; i < 256; i++) begin
            imem[8'(i)] = {cpuPkg::opcodeOri, 10'd0, 16'(i)};
        end
        loadPtr = 0;
        expStores.delete();
    endtask

    // Marker store to the last word, then spin on a branch to itself
    task automatic emitDone();
        emitI(cpuPkg::opcodeOri, 5'd30, 5'd0, doneMarker);
        emitStore(5'd30, 16'h03fc);
        emitI(cpuPkg::opcodeBeq, 5'd0, 5'd0, 16'hffff);
    endtask

    task automatic resetDut();
        int cycles;
        bit asserted;
        bit released;
        cycles = 0;
        asserted = 1'b0;
        released = 1'b0;
        @(negedge clk);
        resetReq <= 1'b1;
        @(negedge clk);
        resetReq <= 1'b0;
        while (!released && cycles < resetTimeout) begin
            @(posedge clk);
            cycles++;
            if (rst) begin
                asserted = 1'b1;
            end else if (asserted) begin
                released = 1'b1;
            end
            @(negedge clk);
            // State left by the last reset edge
            if (asserted && !released) begin
                pcAtRelease = imemAddr;
                reqAtRelease = dmemReq;
            end
        end
        if (!released) begin
            $display("ERROR: timed out waiting for reset to finish");
            failures++;
        end
    endtask

    task automatic runProgram(input string name);
        int cycles;
        bit done;
        cpuPkg::dmemReq_t req;
        cycles = 0;
        done = 1'b0;
        gotStores.delete();
        resetDut();
        while (!done && cycles < doneTimeout) begin
            @(negedge clk);
            cycles++;
            req = dmemReq;
            if (req.write && req.addr == doneAddr) begin
                done = 1'b1;
            end else if (req.write || req.read) begin
                if (!req.write) begin
                    req.wdata = '0;
                end
                gotStores.push_back(req);
            end
        end
        if (!done) begin
            $display("ERROR %s: timed out waiting for store", name);
            failures++;
        end
        if (gotStores.size() != expStores.size()) begin
            $display("ERROR %s: expected %0d data requests but saw %0d", name,
                expStores.size(), gotStores.size());
            failures++;
        end
        for (int i = 0; i < expStores.size() && i < gotStores.size(); i++) begin
            checkReq($sformatf("%s request %0d", name, i), expStores[i], gotStores[i]);
        end
    endtask

    task automatic testReset();
        newProgram();
        emitDone();
        resetDut();
        checkWord("reset pc", 32'd0, {2'b00, pcAtRelease});
        checkReq("reset dmem request", '0, reqAtRelease);
    endtask

    task automatic testAlu();
        cpuPkg::word_t r;
        logic [15:0] a;
        logic [15:0] b;
        logic [4:0] sh;
        cpuPkg::word_t ra;
        cpuPkg::word_t rb;
        r = nextRandom();
        a = r[15:0];
        b = r[31:16];
        r = nextRandom();
        sh = r[4:0];
        ra = signExt(a);
        rb = signExt(b);
        newProgram();
        emitI(cpuPkg::opcodeAddiu, 5'd1, 5'd0, a);
        emitI(cpuPkg::opcodeAddiu, 5'd2, 5'd0, b);
        emitR(cpuPkg::functAddu, 5'd3, 5'd1, 5'd2, 5'd0);
        place(32'h0);
        emitStore(5'd3, 16'h0000);
        emitR(cpuPkg::functSubu, 5'd4, 5'd1, 5'd2, 5'd0);
        place(32'h0);
        emitStore(5'd4, 16'h0004);
        emitR(cpuPkg::functAnd, 5'd5, 5'd1, 5'd2, 5'd0);
        place(32'h0);
        emitStore(5'd5, 16'h0008);
        emitR(cpuPkg::functOr, 5'd6, 5'd1, 5'd2, 5'd0);
        place(32'h0);
        emitStore(5'd6, 16'h000c);
        emitR(cpuPkg::functSlt, 5'd7, 5'd1, 5'd2, 5'd0);
        place(32'h0);
        emitStore(5'd7, 16'h0010);
        emitR(cpuPkg::functSll, 5'd8, 5'd0, 5'd2, sh);
        place(32'h0);
        emitStore(5'd8, 16'h0014);
        emitI(cpuPkg::opcodeOri, 5'd9, 5'd1, b);
        place(32'h0);
        emitStore(5'd9, 16'h0018);
        emitDone();
        expectStore(16'h0000, ra + rb);
        expectStore(16'h0004, ra - rb);
        expectStore(16'h0008, ra & rb);
        expectStore(16'h000c, ra | rb);
        expectStore(16'h0010, ($signed(ra) < $signed(rb)) ? 32'd1 : 32'd0);
        expectStore(16'h0014, rb << sh);
        expectStore(16'h0018, ra | {16'h0000, b});
        runProgram("alu");
    endtask

    task automatic testForwarding();
        cpuPkg::word_t r;
        cpuPkg::word_t v1;
        cpuPkg::word_t v2;
        cpuPkg::word_t v3;
        cpuPkg::word_t v4;
        r = nextRandom();
        v1 = signExt(r[15:0]);
        v2 = v1 + v1;
        v3 = v1 - v2;
        v4 = v3 + signExt(r[31:16]);
        newProgram();
        // Each instruction reads the one just before it
        emitI(cpuPkg::opcodeAddiu, 5'd1, 5'd0, r[15:0]);
        emitR(cpuPkg::functAddu, 5'd2, 5'd1, 5'd1, 5'd0);
        emitR(cpuPkg::functSubu, 5'd3, 5'd1, 5'd2, 5'd0);
        emitI(cpuPkg::opcodeAddiu, 5'd4, 5'd3, r[31:16]);
        emitStore(5'd4, 16'h0020);
        emitStore(5'd3, 16'h0024);
        emitStore(5'd2, 16'h0028);
        emitStore(5'd1, 16'h002c);
        emitDone();
        expectStore(16'h0020, v4);
        expectStore(16'h0024, v3);
        expectStore(16'h0028, v2);
        expectStore(16'h002c, v1);
        runProgram("forwarding");
    endtask

    task automatic testLoadUse();
        cpuPkg::word_t r;
        cpuPkg::word_t value;
        cpuPkg::word_t addend;
        r = nextRandom();
        value = signExt(r[15:0]);
        addend = signExt(r[31:16]);
        newProgram();
        emitI(cpuPkg::opcodeAddiu, 5'd4, 5'd0, r[31:16]);
        emitI(cpuPkg::opcodeAddiu, 5'd1, 5'd0, r[15:0]);
        emitStore(5'd1, 16'h0040);
        emitI(cpuPkg::opcodeLw, 5'd2, 5'd0, 16'h0040);
        emitR(cpuPkg::functAddu, 5'd3, 5'd2, 5'd4, 5'd0);
        emitStore(5'd3, 16'h0044);
        // Loaded value used as store data right away
        emitI(cpuPkg::opcodeLw, 5'd5, 5'd0, 16'h0040);
        emitStore(5'd5, 16'h0048);
        emitDone();
        expectStore(16'h0040, value);
        expectLoad(16'h0040);
        expectStore(16'h0044, value + addend);
        expectLoad(16'h0040);
        expectStore(16'h0048, value);
        runProgram("load-use");
        checkWord("load-use memory", value + addend, dmem[8'd17]);
    endtask

    task automatic testBranches();
        cpuPkg::word_t r;
        cpuPkg::word_t x;
        r = nextRandom();
        x = signExt(r[15:0]);
        newProgram();
        emitI(cpuPkg::opcodeAddiu, 5'd1, 5'd0, r[15:0]);
        emitI(cpuPkg::opcodeAddiu, 5'd2, 5'd0, r[15:0]);
        emitI(cpuPkg::opcodeAddiu, 5'd3, 5'd1, 16'd1);
        emitI(cpuPkg::opcodeBeq, 5'd2, 5'd1, 16'd2);
        emitStore(5'd1, 16'h0080);
        emitStore(5'd1, 16'h0084);
        emitStore(5'd2, 16'h0088);
        emitI(cpuPkg::opcodeBeq, 5'd3, 5'd1, 16'd2);
        emitStore(5'd3, 16'h008c);
        emitStore(5'd3, 16'h0090);
        emitI(cpuPkg::opcodeBne, 5'd3, 5'd1, 16'd2);
        emitStore(5'd1, 16'h0094);
        emitStore(5'd1, 16'h0098);
        emitStore(5'd3, 16'h009c);
        emitI(cpuPkg::opcodeBne, 5'd2, 5'd1, 16'd2);
        emitStore(5'd1, 16'h00a0);
        emitStore(5'd2, 16'h00a4);
        emitDone();
        expectStore(16'h0088, x);
        expectStore(16'h008c, x + 32'd1);
        expectStore(16'h0090, x + 32'd1);
        expectStore(16'h009c, x + 32'd1);
        expectStore(16'h00a0, x);
        expectStore(16'h00a4, x);
        runProgram("branches");
    endtask

    task automatic testJumps();
        cpuPkg::word_t r;
        cpuPkg::word_t jalAddr;
        r = nextRandom();
        jalAddr = 32'd16;
        newProgram();
        emitI(cpuPkg::opcodeAddiu, 5'd1, 5'd0, r[15:0]);
        emitJ(cpuPkg::opcodeJ, 32'd16);
        emitStore(5'd1, 16'h00c0);
        emitStore(5'd1, 16'h00c4);
        emitJ(cpuPkg::opcodeJal, 32'd32);
        emitStore(5'd31, 16'h00c8);
        emitJ(cpuPkg::opcodeJ, 32'd40);
        emitStore(5'd1, 16'h00cc);
        // Subroutine at byte 32
        emitStore(5'd1, 16'h00d0);
        emitR(cpuPkg::functJr, 5'd0, 5'd31, 5'd0, 5'd0);
        emitDone();
        expectStore(16'h00d0, signExt(r[15:0]));
        expectStore(16'h00c8, jalAddr + 32'd4);
        runProgram("jumps");
    endtask

    initial begin
        testReset();
        testAlu();
        testForwarding();
        testLoadUse();
        testBranches();
        testJumps();
        $display("Summary: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
logic/cpuPkg.sv
logic/decodeUnit.sv
logic/registerFile.sv
logic/aluUnit.sv
logic/hazardUnit.sv
logic/stageReg.sv
logic/mipsPipeline.sv
test/tbClock.sv
test/tbMips.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tbMips \
    -f project.f -o tbMips || exit 1
out=$(./obj_dir/tbMips)
echo "$out"
echo "$out" | grep -qx "All tests passed" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
